//--- Bender.yml
package:
  name: axi_lite_mem

sources:
  - include_dirs:
      - source
    files:
      - source/axi_lite_pkg.sv
      - source/axi_lite_to_axi.sv
      - source/axi_mem_slave.sv
      - source/axi_lite_mem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_axi_lite_mem.sv

//--- list.f
+incdir+source
source/axi_lite_pkg.sv
source/axi_lite_to_axi.sv
source/axi_mem_slave.sv
source/axi_lite_mem_top.sv
verification/tb_axi_lite_mem.sv

//--- source/axi_lite_consts.svh
// Width and size constants for the AXI-Lite to AXI memory subsystem
// Shared by the package, the bridge, the memory slave and the top level
`ifndef AXI_LITE_CONSTS_SVH
`define AXI_LITE_CONSTS_SVH

// Byte address width on both the AXI-Lite and the AXI4 side
`define AXI_ADDR_WIDTH 32

// Data bus width, which must be a whole number of bytes
`define AXI_DATA_WIDTH 32

// One strobe bit for every data byte
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

// The AXI4 id field is carried but the bridge only ever issues id 0
`define AXI_ID_WIDTH 8

// User sideband width on every AXI4 channel
`define AXI_USER_WIDTH 8

// Depth of the memory in data words
// The decoded range starts at byte address 0 and ends just below
// MEM_WORDS times the bus width in bytes
`define MEM_WORDS 256

`endif

//--- source/axi_lite_mem_top.sv
// AXI-Lite memory subsystem top level
// Connects the AXI-Lite to AXI4 bridge to the single-beat memory slave
`timescale 1ns/10ps
`include "axi_lite_consts.svh"

module axi_lite_mem_top import axi_lite_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  lite_req_t lite_req,
  output lite_rsp_t lite_rsp
);

  // Internal AXI4 link between the bridge and the memory
  axi_req_t axi_req;
  axi_rsp_t axi_rsp;

  // Bridge registers the lite requests and widens them to AXI4
  axi_lite_to_axi u_bridge (
    .clk      (clk),
    .rst_n    (rst_n),
    .lite_req (lite_req),
    .lite_rsp (lite_rsp),
    .axi_req  (axi_req),
    .axi_rsp  (axi_rsp)
  );

  // Memory answers each beat one cycle after accepting it
  axi_mem_slave u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp)
  );

endmodule

//--- source/axi_lite_pkg.sv
// Channel and bundle types for the AXI-Lite to AXI memory subsystem
// Holds the response codes, the fixed AXI4 field values and all channel structs
`include "axi_lite_consts.svh"

package axi_lite_pkg;

  // Response codes used on B and R
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Protection bits pass unchanged from AXI-Lite to AXI4
  typedef logic [2:0] prot_t;

  // Burst type and size encodings for single-beat AXI4 transfers
  typedef logic [1:0] burst_t;
  localparam burst_t BURST_INCR = 2'b01;
  typedef logic [2:0] size_t;
  // A full-width beat moves log2 of the strobe width in bytes
  localparam size_t SIZE_FULL = size_t'($clog2(`AXI_STRB_WIDTH));

  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
  typedef logic [`AXI_STRB_WIDTH-1:0] strb_t;
  typedef logic [`AXI_ID_WIDTH-1:0]   id_t;
  typedef logic [`AXI_USER_WIDTH-1:0] user_t;

  // AXI-Lite address beat shared by AW and AR
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } lite_ax_t;

  // AXI-Lite write data beat
  typedef struct packed {
    data_t data;
    strb_t strb;
  } lite_w_t;

  // AXI-Lite read data beat
  typedef struct packed {
    data_t data;
    resp_t resp;
  } lite_r_t;

  // AXI4 address beat shared by AW and AR
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    size_t      size;
    burst_t     burst;
    logic       lock;
    logic [3:0] cache;
    prot_t      prot;
    user_t      user;
  } axi_ax_t;

  // AXI4 write data beat
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } axi_w_t;

  // AXI4 write response beat
  typedef struct packed {
    id_t   id;
    resp_t resp;
    user_t user;
  } axi_b_t;

  // AXI4 read data beat
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
    user_t user;
  } axi_r_t;

  // Everything an AXI-Lite master drives
  typedef struct packed {
    lite_ax_t aw;
    logic     aw_valid;
    lite_w_t  w;
    logic     w_valid;
    logic     b_ready;
    lite_ax_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  // Everything an AXI-Lite slave drives
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    resp_t   b_resp;
    logic    b_valid;
    logic    ar_ready;
    lite_r_t r;
    logic    r_valid;
  } lite_rsp_t;

  // Everything an AXI4 master drives
  typedef struct packed {
    axi_ax_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  // Everything an AXI4 slave drives
  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    axi_b_t b;
    logic   b_valid;
    logic   ar_ready;
    axi_r_t r;
    logic   r_valid;
  } axi_rsp_t;

endpackage

//--- source/axi_lite_to_axi.sv
// Bridge from AXI-Lite to single-beat AXI4
// AW, W and AR each go through a two-entry skid buffer with a registered ready
// B and R come back combinationally with the AXI4-only fields dropped
`timescale 1ns/10ps
`include "axi_lite_consts.svh"

module axi_lite_to_axi import axi_lite_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  lite_req_t lite_req,
  output lite_rsp_t lite_rsp,
  output axi_req_t  axi_req,
  input  axi_rsp_t  axi_rsp
);

  // The three request channels share one buffer implementation
  localparam int unsigned NUM_CH = 3;
  localparam int unsigned CH_AW  = 0;
  localparam int unsigned CH_W   = 1;
  localparam int unsigned CH_AR  = 2;

  // Every slot is wide enough for the widest request beat
  localparam int unsigned AX_W   = $bits(lite_ax_t);
  localparam int unsigned WD_W   = $bits(lite_w_t);
  localparam int unsigned SLOT_W = (AX_W > WD_W) ? AX_W : WD_W;

  logic [NUM_CH-1:0]             in_valid;
  logic [NUM_CH-1:0]             in_ready;
  logic [NUM_CH-1:0][SLOT_W-1:0] in_data;
  logic [NUM_CH-1:0]             out_valid;
  logic [NUM_CH-1:0]             out_ready;
  logic [NUM_CH-1:0][SLOT_W-1:0] out_data;

  lite_ax_t aw_slot;
  lite_w_t  w_slot;
  lite_ax_t ar_slot;

  // Lite side of the buffers
  assign in_valid[CH_AW] = lite_req.aw_valid;
  assign in_valid[CH_W]  = lite_req.w_valid;
  assign in_valid[CH_AR] = lite_req.ar_valid;
  assign in_data[CH_AW]  = SLOT_W'(lite_req.aw);
  assign in_data[CH_W]   = SLOT_W'(lite_req.w);
  assign in_data[CH_AR]  = SLOT_W'(lite_req.ar);

  // AXI4 side of the buffers
  assign out_ready[CH_AW] = axi_rsp.aw_ready;
  assign out_ready[CH_W]  = axi_rsp.w_ready;
  assign out_ready[CH_AR] = axi_rsp.ar_ready;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_skid
    logic [1:0][SLOT_W-1:0] slot_q;
    logic                   wr_ptr_q;
    logic                   rd_ptr_q;
    logic [1:0]             cnt_q;
    logic [1:0]             cnt_d;
    logic                   ready_q;
    logic                   push;
    logic                   pop;

    assign push  = in_valid[ch] & ready_q;
    assign pop   = out_valid[ch] & out_ready[ch];
    assign cnt_d = cnt_q + 2'(push) - 2'(pop);

    // Ready is registered from the next occupancy so it never sees
    // the downstream ready within the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q    <= 2'd0;
        wr_ptr_q <= 1'b0;
        rd_ptr_q <= 1'b0;
        ready_q  <= 1'b0;
      end else begin
        cnt_q   <= cnt_d;
        ready_q <= (cnt_d != 2'd2);
        if (push) begin
          wr_ptr_q <= ~wr_ptr_q;
        end
        if (pop) begin
          rd_ptr_q <= ~rd_ptr_q;
        end
      end
    end

    // Entries hold payload only and are qualified by the count
    always_ff @(posedge clk) begin
      if (push) begin
        slot_q[wr_ptr_q] <= in_data[ch];
      end
    end

    // The oldest entry is presented until the AXI4 side takes it
    assign out_valid[ch] = (cnt_q != 2'd0);
    assign out_data[ch]  = slot_q[rd_ptr_q];
    assign in_ready[ch]  = ready_q;

    // Once offered on AXI4 a beat stays put until the slave accepts it
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[ch] && !out_ready[ch] |=> out_valid[ch] && $stable(out_data[ch]))
      else $error("AXI4 request on channel %0d changed before its handshake", ch);
  end

  assign aw_slot = lite_ax_t'(out_data[CH_AW][AX_W-1:0]);
  assign w_slot  = lite_w_t'(out_data[CH_W][WD_W-1:0]);
  assign ar_slot = lite_ax_t'(out_data[CH_AR][AX_W-1:0]);

  // AW and AR become single full-width INCR beats with id and user 0
  assign axi_req.aw = '{id: '0, addr: aw_slot.addr, len: 8'd0, size: SIZE_FULL,
                        burst: BURST_INCR, lock: 1'b0, cache: 4'd0,
                        prot: aw_slot.prot, user: '0};
  assign axi_req.ar = '{id: '0, addr: ar_slot.addr, len: 8'd0, size: SIZE_FULL,
                        burst: BURST_INCR, lock: 1'b0, cache: 4'd0,
                        prot: ar_slot.prot, user: '0};
  assign axi_req.aw_valid = out_valid[CH_AW];
  assign axi_req.ar_valid = out_valid[CH_AR];

  // Every write is a single beat so last is always set
  assign axi_req.w       = '{data: w_slot.data, strb: w_slot.strb, last: 1'b1, user: '0};
  assign axi_req.w_valid = out_valid[CH_W];

  assign lite_rsp.aw_ready = in_ready[CH_AW];
  assign lite_rsp.w_ready  = in_ready[CH_W];
  assign lite_rsp.ar_ready = in_ready[CH_AR];

  // Responses pass straight through in both directions
  assign lite_rsp.b_resp  = axi_rsp.b.resp;
  assign lite_rsp.b_valid = axi_rsp.b_valid;
  assign axi_req.b_ready  = lite_req.b_ready;
  assign lite_rsp.r       = '{data: axi_rsp.r.data, resp: axi_rsp.r.resp};
  assign lite_rsp.r_valid = axi_rsp.r_valid;
  assign axi_req.r_ready  = lite_req.r_ready;

  // Only id 0 is ever issued, so the slave must echo nothing else
  a_b_id_zero: assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp.b_valid |-> axi_rsp.b.id == '0)
    else $error("B response arrived with id %0h", axi_rsp.b.id);

  a_r_id_zero: assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp.r_valid |-> axi_rsp.r.id == '0)
    else $error("R response arrived with id %0h", axi_rsp.r.id);

endmodule

//--- source/axi_mem_slave.sv
// Single-beat AXI4 memory slave
// Applies write strobes per byte and answers SLVERR outside its word range
// Write and read paths each hold one pending response
`timescale 1ns/10ps
`include "axi_lite_consts.svh"

module axi_mem_slave import axi_lite_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  axi_req_t axi_req,
  output axi_rsp_t axi_rsp
);

  localparam int unsigned ADDR_W = `AXI_ADDR_WIDTH;
  localparam int unsigned DATA_W = `AXI_DATA_WIDTH;
  localparam int unsigned STRB_W = `AXI_STRB_WIDTH;
  // Byte offset bits inside one data word
  localparam int unsigned OFFSET = $clog2(STRB_W);
  // Index bits into the word array
  localparam int unsigned IDX_W  = $clog2(`MEM_WORDS);
  // First word index that lies outside the memory
  localparam logic [ADDR_W-1:0] MEM_LIMIT = ADDR_W'(`MEM_WORDS);

  logic [DATA_W-1:0] mem_q [`MEM_WORDS];

  logic             wr_accept;
  logic             rd_accept;
  logic             aw_in_range;
  logic             ar_in_range;
  logic [IDX_W-1:0] aw_idx;
  logic [IDX_W-1:0] ar_idx;

  // Pending responses
  logic   b_valid_q;
  axi_b_t b_q;
  logic   r_valid_q;
  axi_r_t r_q;

  // Range check uses the full word address so aliases above the
  // memory are rejected instead of wrapping
  assign aw_in_range = (axi_req.aw.addr >> OFFSET) < MEM_LIMIT;
  assign ar_in_range = (axi_req.ar.addr >> OFFSET) < MEM_LIMIT;
  assign aw_idx      = axi_req.aw.addr[OFFSET +: IDX_W];
  assign ar_idx      = axi_req.ar.addr[OFFSET +: IDX_W];

  // A write needs both its address and its data, and a free B slot
  assign wr_accept = axi_req.aw_valid & axi_req.w_valid & ~b_valid_q;

  // A read only needs a free R slot
  assign rd_accept = axi_req.ar_valid & ~r_valid_q;

  // AW and W are taken together in one cycle
  assign axi_rsp.aw_ready = wr_accept;
  assign axi_rsp.w_ready  = wr_accept;
  assign axi_rsp.ar_ready = rd_accept;

  // Strobed write of the addressed word
  // Out-of-range writes leave the array untouched
  always_ff @(posedge clk) begin
    if (wr_accept && aw_in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (axi_req.w.strb[b]) begin
          mem_q[aw_idx][8*b +: 8] <= axi_req.w.data[8*b +: 8];
        end
      end
    end
  end

  // B is raised the cycle after acceptance and held until taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_valid_q <= 1'b0;
    end else if (wr_accept) begin
      b_valid_q <= 1'b1;
    end else if (axi_req.b_ready) begin
      b_valid_q <= 1'b0;
    end
  end

  // B payload echoes the request id and reports the range check
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      b_q.id   <= axi_req.aw.id;
      b_q.resp <= aw_in_range ? RESP_OKAY : RESP_SLVERR;
      b_q.user <= '0;
    end
  end

  // R follows the same pattern as B on the read side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_valid_q <= 1'b0;
    end else if (rd_accept) begin
      r_valid_q <= 1'b1;
    end else if (axi_req.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // Read data is captured at acceptance so a later write cannot
  // disturb a response that is still waiting
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      r_q.id   <= axi_req.ar.id;
      r_q.data <= ar_in_range ? mem_q[ar_idx] : '0;
      r_q.resp <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
      r_q.last <= 1'b1;
      r_q.user <= '0;
    end
  end

  assign axi_rsp.b       = b_q;
  assign axi_rsp.b_valid = b_valid_q;
  assign axi_rsp.r       = r_q;
  assign axi_rsp.r_valid = r_valid_q;

  // The master must only ever send single beats
  a_len_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (axi_req.aw_valid |-> axi_req.aw.len == 8'd0) and
    (axi_req.ar_valid |-> axi_req.ar.len == 8'd0))
    else $error("AXI4 burst length other than one beat");

  // Every beat must cover the whole data bus
  a_size_full: assert property (@(posedge clk) disable iff (!rst_n)
    (axi_req.aw_valid |-> axi_req.aw.size == SIZE_FULL) and
    (axi_req.ar_valid |-> axi_req.ar.size == SIZE_FULL))
    else $error("AXI4 size narrower than the data bus");

endmodule

//--- verification/tb_axi_lite_mem.sv
// Testbench for the AXI-Lite memory subsystem
// Drives AXI-Lite writes and reads against a reference memory model and
// checks every B and R handshake with concurrent assertions
`timescale 1ns/10ps
`include "axi_lite_consts.svh"

module tb_axi_lite_mem import axi_lite_pkg::*; ();

  localparam logic [31:0] SEED = 32'h36498ddb;
  localparam int RESET_CYCLES   = 8;
  localparam int NUM_DIRECTED   = 7;
  localparam int NUM_RANDOM     = 400;
  // Every memory word is written once before the tests start
  localparam int TOTAL_TXN      = `MEM_WORDS + NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = 10 * TOTAL_TXN + RESET_CYCLES;
  localparam int BYTES          = `AXI_DATA_WIDTH / 8;
  localparam int MEM_BYTES      = `MEM_WORDS * BYTES;
  localparam int OFFSET         = $clog2(BYTES);
  localparam int IDX_W          = $clog2(`MEM_WORDS);

  logic      clk;
  logic      rst_n;
  lite_req_t req_drv;
  logic      b_ready_drv;
  logic      r_ready_drv;
  lite_req_t lite_req;
  lite_rsp_t lite_rsp;

  // Reference memory and the responses still owed by the DUT, oldest first
  data_t   ref_mem [`MEM_WORDS];
  resp_t   b_exp_q [$];
  lite_r_t r_exp_q [$];
  int      b_pending = 0;
  int      r_pending = 0;
  resp_t   b_head = RESP_OKAY;
  lite_r_t r_head = '0;

  int          b_seen = 0;
  int          r_seen = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          cycles = 0;
  logic        req_seen = 1'b0;
  logic [31:0] stim_rng;

  axi_lite_mem_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .lite_req (lite_req),
    .lite_rsp (lite_rsp)
  );

  // Response readies come from their own process, the rest from the driver
  always_comb begin
    lite_req         = req_drv;
    lite_req.b_ready = b_ready_drv;
    lite_req.r_ready = r_ready_drv;
  end

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Byte lanes with a set strobe bit take the new data
  function automatic data_t merge_bytes(input data_t old, input data_t data,
                                        input strb_t strb);
    data_t mask;
    for (int b = 0; b < BYTES; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old & ~mask) | (data & mask);
  endfunction

  // The memory covers the bytes from address 0 up to its size
  function automatic logic in_range(input addr_t addr);
    return addr < addr_t'(MEM_BYTES);
  endfunction

  // Initial memory contents, a mix of every address bit
  function automatic data_t fill_word(input addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c96e1;
  endfunction

  // Heads of the queues are copied into plain variables for the assertions
  task automatic update_heads();
    b_pending = b_exp_q.size();
    b_head    = (b_pending != 0) ? b_exp_q[0] : RESP_OKAY;
    r_pending = r_exp_q.size();
    r_head    = (r_pending != 0) ? r_exp_q[0] : '0;
  endtask

  task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
    logic aw_pend;
    logic w_pend;
    logic aw_fire;
    logic w_fire;
    // Reads in flight finish first, so the memory sees the same order as the model
    while (r_pending != 0) begin
      @(negedge clk);
    end
    req_seen         = 1'b1;
    req_drv.aw       = '{addr: addr, prot: prot_t'(stim_rng[2:0])};
    req_drv.aw_valid = 1'b1;
    req_drv.w        = '{data: data, strb: strb};
    req_drv.w_valid  = 1'b1;
    aw_pend          = 1'b1;
    w_pend           = 1'b1;
    // Lite ready is registered, so its value at the falling edge decides the handshake
    while (aw_pend || w_pend) begin
      aw_fire = aw_pend && lite_rsp.aw_ready;
      w_fire  = w_pend && lite_rsp.w_ready;
      @(negedge clk);
      if (aw_fire) begin
        aw_pend          = 1'b0;
        req_drv.aw_valid = 1'b0;
      end
      if (w_fire) begin
        w_pend          = 1'b0;
        req_drv.w_valid = 1'b0;
      end
    end
    if (in_range(addr)) begin
      ref_mem[addr[OFFSET +: IDX_W]] = merge_bytes(ref_mem[addr[OFFSET +: IDX_W]], data, strb);
      b_exp_q.push_back(RESP_OKAY);
    end else begin
      b_exp_q.push_back(RESP_SLVERR);
    end
    update_heads();
  endtask

  task automatic read_word(input addr_t addr);
    logic ar_fire;
    // All earlier writes must have landed before the model predicts the data
    while (b_pending != 0) begin
      @(negedge clk);
    end
    req_seen         = 1'b1;
    req_drv.ar       = '{addr: addr, prot: prot_t'(stim_rng[5:3])};
    req_drv.ar_valid = 1'b1;
    ar_fire          = 1'b0;
    while (!ar_fire) begin
      ar_fire = lite_rsp.ar_ready;
      @(negedge clk);
    end
    req_drv.ar_valid = 1'b0;
    if (in_range(addr)) begin
      r_exp_q.push_back(lite_r_t'{data: ref_mem[addr[OFFSET +: IDX_W]], resp: RESP_OKAY});
    end else begin
      r_exp_q.push_back(lite_r_t'{data: '0, resp: RESP_SLVERR});
    end
    update_heads();
  endtask

  task automatic report_counts();
    $display("Responses checked: %0d B, %0d R; errors: %0d value, %0d protocol",
             b_seen, r_seen, value_errors, protocol_errors);
  endtask

  // Completed handshakes retire the head of their queue
  always @(posedge clk) begin
    if (rst_n && lite_rsp.b_valid && lite_req.b_ready && b_pending != 0) begin
      void'(b_exp_q.pop_front());
      b_seen++;
      update_heads();
    end
    if (rst_n && lite_rsp.r_valid && lite_req.r_ready && r_pending != 0) begin
      void'(r_exp_q.pop_front());
      r_seen++;
      update_heads();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles with %0d B and %0d R responses missing",
               cycles, b_pending, r_pending);
      report_counts();
      $display("Some tests failed");
      $finish;
    end
  end

  // Random low stretches on b_ready and r_ready, from a second stream of the seed
  initial begin
    logic [31:0] rng;
    int          b_hold;
    int          r_hold;
    rng         = ~SEED;
    b_hold      = 0;
    r_hold      = 0;
    b_ready_drv = 1'b0;
    r_ready_drv = 1'b0;
    forever begin
      @(negedge clk);
      rng = xorshift32(rng);
      if (b_hold > 0) begin
        b_hold--;
        b_ready_drv = 1'b0;
      end else if (rng[2:0] == 3'd0) begin
        b_hold      = rng[5:4];
        b_ready_drv = 1'b0;
      end else begin
        b_ready_drv = 1'b1;
      end
      if (r_hold > 0) begin
        r_hold--;
        r_ready_drv = 1'b0;
      end else if (rng[10:8] == 3'd0) begin
        r_hold      = rng[13:12];
        r_ready_drv = 1'b0;
      end else begin
        r_ready_drv = 1'b1;
      end
    end
  end

  // Each B and R handshake must match the oldest expected response
  a_b_expected: assert property (@(posedge clk) disable iff (!rst_n)
    lite_rsp.b_valid && lite_req.b_ready |-> b_pending != 0)
    else begin
      protocol_errors++;
      $display("A write response arrived with no write outstanding");
    end

  a_b_resp: assert property (@(posedge clk) disable iff (!rst_n)
    lite_rsp.b_valid && lite_req.b_ready && b_pending != 0 |-> lite_rsp.b_resp == b_head)
    else begin
      value_errors++;
      $display("** Error: lite_rsp.b_resp expected %h, got %h",
               $sampled(b_head), $sampled(lite_rsp.b_resp));
    end

  a_r_expected: assert property (@(posedge clk) disable iff (!rst_n)
    lite_rsp.r_valid && lite_req.r_ready |-> r_pending != 0)
    else begin
      protocol_errors++;
      $display("A read response arrived with no read outstanding");
    end

  a_r_data: assert property (@(posedge clk) disable iff (!rst_n)
    lite_rsp.r_valid && lite_req.r_ready && r_pending != 0 |-> lite_rsp.r.data == r_head.data)
    else begin
      value_errors++;
      $display("** Error: lite_rsp.r.data expected %h, got %h",
               $sampled(r_head.data), $sampled(lite_rsp.r.data));
    end

  a_r_resp: assert property (@(posedge clk) disable iff (!rst_n)
    lite_rsp.r_valid && lite_req.r_ready && r_pending != 0 |-> lite_rsp.r.resp == r_head.resp)
    else begin
      value_errors++;
      $display("** Error: lite_rsp.r.resp expected %h, got %h",
               $sampled(r_head.resp), $sampled(lite_rsp.r.resp));
    end

  // A stalled response keeps valid and payload until it is taken
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    lite_rsp.b_valid && !lite_req.b_ready |=> lite_rsp.b_valid && $stable(lite_rsp.b_resp))
    else begin
      protocol_errors++;
      $display("The write response changed or dropped before its handshake");
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    lite_rsp.r_valid && !lite_req.r_ready |=> lite_rsp.r_valid && $stable(lite_rsp.r))
    else begin
      protocol_errors++;
      $display("The read response changed or dropped before its handshake");
    end

  // Readies stay low in reset, and no response shows before the first request
  a_reset_idle: assert property (@(posedge clk) !rst_n && cycles > 1 |->
    !(lite_rsp.aw_ready || lite_rsp.w_ready || lite_rsp.ar_ready ||
      lite_rsp.b_valid || lite_rsp.r_valid))
    else begin
      protocol_errors++;
      $display("A ready or valid output was high during reset");
    end

  a_no_early_rsp: assert property (@(posedge clk) rst_n && !req_seen |->
    !lite_rsp.b_valid && !lite_rsp.r_valid)
    else begin
      protocol_errors++;
      $display("A response appeared before any request was sent");
    end

  initial begin
    logic [31:0] op;
    logic [31:0] wdata;
    addr_t       addr;
    strb_t       strb;
    req_drv  = '0;
    rst_n    = 1'b0;
    stim_rng = SEED;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
    end
    rst_n = 1'b1;
    @(negedge clk);

    // Fill every word so that later reads never see unknown data
    for (int i = 0; i < `MEM_WORDS; i++) begin
      write_word(addr_t'(i * BYTES), fill_word(addr_t'(i * BYTES)), '1);
    end

    // Full-strobe write read back from the same address
    write_word(addr_t'(32'h40), 32'hcafe_f00d, '1);
    read_word(addr_t'(32'h40));
    // Partial strobe merges two new bytes into the old word
    write_word(addr_t'(32'h44), 32'h1122_3344, 4'b0101);
    read_word(addr_t'(32'h44));
    // The out-of-range write aliases word 0x48 in the index bits only
    write_word(addr_t'(MEM_BYTES + 32'h48), 32'hdead_beef, '1);
    read_word(addr_t'(MEM_BYTES + 32'h48));
    read_word(addr_t'(32'h48));

    // Random mix with about one access in sixteen outside the memory
    for (int n = 0; n < NUM_RANDOM; n++) begin
      stim_rng = xorshift32(stim_rng);
      op       = stim_rng;
      stim_rng = xorshift32(stim_rng);
      wdata    = stim_rng;
      if (op[3:0] == 4'd0) begin
        addr = addr_t'(MEM_BYTES) + addr_t'({op[19:8], 2'b00});
      end else begin
        addr = (addr_t'(op[31:8]) % `MEM_WORDS) << OFFSET;
      end
      strb = op[6] ? '1 : strb_t'(op[23:20]);
      if (op[7]) begin
        write_word(addr, wdata, strb);
      end else begin
        read_word(addr);
      end
    end

    while (b_pending != 0 || r_pending != 0) begin
      @(negedge clk);
    end
    // A few idle cycles catch any extra response
    repeat (4) begin
      @(negedge clk);
    end
    report_counts();
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
